// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_mips_top
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

`define MIPS_RESET_PC     32'hBFC00000
`define MIPS_NUM_REGS     32

// primary opcodes
`define MIPS_OP_SPECIAL   6'h00
`define MIPS_OP_ADDIU     6'h09
`define MIPS_OP_ORI       6'h0d
`define MIPS_OP_LUI       6'h0f
`define MIPS_OP_LW        6'h23
`define MIPS_OP_SB        6'h28
`define MIPS_OP_SW        6'h2b

// function field under SPECIAL
`define MIPS_FUNCT_ADDU   6'h21
`define MIPS_FUNCT_SUBU   6'h23
`define MIPS_FUNCT_AND    6'h24
`define MIPS_FUNCT_OR     6'h25
`define MIPS_FUNCT_XOR    6'h26
`define MIPS_FUNCT_SLT    6'h2a

`endif

// File: common/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  byte_en_t;

    // ALU_ADD must stay zero so an all-zero ctrl is a bubble
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      mem_byte;
        alu_op_e   alu_op;
        reg_addr_t dest;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        ctrl_t ctrl;
        word_t operand_a;
        word_t operand_b;
        word_t store_data;
    } id_ex_t;

    typedef struct packed {
        word_t pc;
        ctrl_t ctrl;
        word_t result;
        word_t store_data;
    } ex_mem_t;

    // retiring write, also the shape of both forward paths
    typedef struct packed {
        word_t     pc;
        logic      we;
        reg_addr_t dest;
        word_t     data;
    } wb_t;

endpackage

// File: decode/mips_decode.sv
`timescale 1ns/10ps
`include "mips_macros.svh"
module mips_decode (
    input  logic                clock_i,
    input  logic                rst_i,
    input  logic                data_stall_i,
    input  mips_pkg::word_t     if_pc_i,
    input  mips_pkg::word_t     if_inst_i,
    input  mips_pkg::word_t     rs_data_i,
    input  mips_pkg::word_t     rt_data_i,
    output mips_pkg::reg_addr_t rs_addr_o,
    output mips_pkg::reg_addr_t rt_addr_o,
    input  mips_pkg::wb_t       ex_fwd_i,
    input  mips_pkg::wb_t       mem_fwd_i,
    input  logic                ex_is_load_i,
    output logic                load_stall_o,
    output mips_pkg::id_ex_t    id_ex_o
);
    import mips_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    ctrl_t      ctrl;
    logic       use_imm;
    logic       zero_ext;
    logic       rs_used;
    logic       rt_used;
    word_t      imm;
    word_t      rs_val;
    word_t      rt_val;
    id_ex_t     id_ex_d;
    id_ex_t     id_ex_q;

    // youngest producer wins, r0 never forwarded
    function automatic word_t fwd_sel(input reg_addr_t addr, input word_t rf_data,
                                      input wb_t ex_fwd, input wb_t mem_fwd);
        word_t val;
        if (addr != '0 && ex_fwd.we && ex_fwd.dest == addr) begin
            val = ex_fwd.data;
        end else if (addr != '0 && mem_fwd.we && mem_fwd.dest == addr) begin
            val = mem_fwd.data;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    assign opcode    = if_inst_i[31:26];
    assign rs        = if_inst_i[25:21];
    assign rt        = if_inst_i[20:16];
    assign rd        = if_inst_i[15:11];
    assign funct     = if_inst_i[5:0];
    assign rs_addr_o = rs;
    assign rt_addr_o = rt;

    always_comb begin
        ctrl           = '0;
        ctrl.reg_write = 1'b1;
        ctrl.dest      = rt;
        use_imm        = 1'b1;
        zero_ext       = 1'b0;
        rs_used        = 1'b1;
        rt_used        = 1'b0;
        case (opcode)
            `MIPS_OP_SPECIAL: begin
                ctrl.dest = rd;
                use_imm   = 1'b0;
                rt_used   = 1'b1;
                case (funct)
                    `MIPS_FUNCT_ADDU: ctrl.alu_op = ALU_ADD;
                    `MIPS_FUNCT_SUBU: ctrl.alu_op = ALU_SUB;
                    `MIPS_FUNCT_AND:  ctrl.alu_op = ALU_AND;
                    `MIPS_FUNCT_OR:   ctrl.alu_op = ALU_OR;
                    `MIPS_FUNCT_XOR:  ctrl.alu_op = ALU_XOR;
                    `MIPS_FUNCT_SLT:  ctrl.alu_op = ALU_SLT;
                    default: begin
                        ctrl    = '0;
                        rs_used = 1'b0;
                        rt_used = 1'b0;
                    end
                endcase
            end
            `MIPS_OP_ADDIU: ctrl.alu_op = ALU_ADD;
            `MIPS_OP_ORI: begin
                ctrl.alu_op = ALU_OR;
                zero_ext    = 1'b1;
            end
            `MIPS_OP_LUI: begin
                ctrl.alu_op = ALU_LUI;
                zero_ext    = 1'b1;
                rs_used     = 1'b0;
            end
            `MIPS_OP_LW: ctrl.mem_read = 1'b1;
            `MIPS_OP_SW, `MIPS_OP_SB: begin
                ctrl.reg_write = 1'b0;
                ctrl.dest      = '0;
                ctrl.mem_write = 1'b1;
                ctrl.mem_byte  = (opcode == `MIPS_OP_SB);
                rt_used        = 1'b1;
            end
            default: begin
                ctrl    = '0;
                rs_used = 1'b0;
            end
        endcase
    end

    assign imm    = zero_ext ? {16'h0, if_inst_i[15:0]} : {{16{if_inst_i[15]}}, if_inst_i[15:0]};
    assign rs_val = fwd_sel(rs, rs_data_i, ex_fwd_i, mem_fwd_i);
    assign rt_val = fwd_sel(rt, rt_data_i, ex_fwd_i, mem_fwd_i);

    assign id_ex_d = '{pc: if_pc_i, ctrl: ctrl, operand_a: rs_val,
                       operand_b: use_imm ? imm : rt_val, store_data: rt_val};

    // load in execute feeding this instruction
    assign load_stall_o = ex_is_load_i && ex_fwd_i.dest != '0 &&
                          ((rs_used && ex_fwd_i.dest == rs) || (rt_used && ex_fwd_i.dest == rt));

    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            id_ex_q <= '0;
        end else if (!data_stall_i) begin
            id_ex_q <= load_stall_o ? id_ex_t'('0) : id_ex_d;
        end
    end

    assign id_ex_o = id_ex_q;
endmodule

// File: decode/mips_regfile.sv
`timescale 1ns/10ps
`include "mips_macros.svh"
module mips_regfile (
    input  logic                clock_i,
    input  logic                rst_i,
    input  mips_pkg::reg_addr_t rs_addr_i,
    input  mips_pkg::reg_addr_t rt_addr_i,
    input  mips_pkg::wb_t       wb_i,
    output mips_pkg::word_t     rs_data_o,
    output mips_pkg::word_t     rt_data_o
);
    import mips_pkg::*;

    word_t regs [0:`MIPS_NUM_REGS-1];

    // a write this cycle passes straight through except to r0
    function automatic word_t read_port(input reg_addr_t addr, input word_t stored,
                                        input wb_t wb);
        word_t val;
        if (addr != '0 && wb.we && wb.dest == addr) begin
            val = wb.data;
        end else begin
            val = stored;
        end
        return val;
    endfunction

    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && wb_i.dest != '0) begin
            regs[wb_i.dest] <= wb_i.data;
        end
    end

    assign rs_data_o = read_port(rs_addr_i, regs[rs_addr_i], wb_i);
    assign rt_data_o = read_port(rt_addr_i, regs[rt_addr_i], wb_i);

    a_r0_zero: assert property (@(posedge clock_i) disable iff (rst_i)
        (rs_addr_i != '0 || rs_data_o == '0) && (rt_addr_i != '0 || rt_data_o == '0));
endmodule

// File: execute/mips_execute.sv
`timescale 1ns/10ps
module mips_execute (
    input  logic              clock_i,
    input  logic              rst_i,
    input  logic              data_stall_i,
    input  mips_pkg::id_ex_t  id_ex_i,
    output mips_pkg::ex_mem_t ex_mem_o,
    output mips_pkg::wb_t     ex_fwd_o,
    output logic              ex_is_load_o
);
    import mips_pkg::*;

    word_t   a;
    word_t   b;
    word_t   result;
    ex_mem_t ex_mem_q;

    assign a = id_ex_i.operand_a;
    assign b = id_ex_i.operand_b;

    // loads and stores compute their address with ALU_ADD
    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
            ALU_LUI: result = b << 16;
            default: result = a + b;
        endcase
    end

    // for a load this is the address, decode stalls on it
    assign ex_fwd_o = '{pc: id_ex_i.pc, we: id_ex_i.ctrl.reg_write,
                        dest: id_ex_i.ctrl.dest, data: result};
    assign ex_is_load_o = id_ex_i.ctrl.mem_read;

    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            ex_mem_q <= '0;
        end else if (!data_stall_i) begin
            ex_mem_q <= '{pc: id_ex_i.pc, ctrl: id_ex_i.ctrl, result: result,
                          store_data: id_ex_i.store_data};
        end
    end

    assign ex_mem_o = ex_mem_q;
endmodule

// File: tb/tb_mips_top.sv
`timescale 1ns/10ps
`include "mips_macros.svh"
module tb_mips_top;
    import mips_pkg::*;

    typedef struct packed {
        word_t    addr;
        byte_en_t en;
        word_t    data;
    } store_t;

    logic      clock_i = 1'b0;
    logic      rst_i;
    logic      data_stall_i;
    word_t     inst_sram_addr_o;
    logic      inst_sram_ren_o;
    word_t     inst_sram_rdata_i;
    logic      data_sram_ren_o;
    byte_en_t  data_sram_wen_o;
    word_t     data_sram_addr_o;
    word_t     data_sram_wdata_o;
    word_t     data_sram_rdata_i;
    word_t     debug_wb_pc_o;
    byte_en_t  debug_wb_wen_o;
    reg_addr_t debug_wb_num_o;
    word_t     debug_wb_data_o;

    word_t  imem [0:255];
    word_t  dmem [0:255];
    word_t  ref_mem [0:255];
    word_t  imem_offset;
    word_t  prog [$];
    wb_t    exp_writes [$];
    store_t exp_stores [$];
    int     checks = 0;
    int     mismatches = 0;
    int     other_errors = 0;

    always #5 clock_i = ~clock_i;

    mips_top UUT (
        .clock_i          (clock_i),
        .rst_i            (rst_i),
        .data_stall_i     (data_stall_i),
        .inst_sram_addr_o (inst_sram_addr_o),
        .inst_sram_ren_o  (inst_sram_ren_o),
        .inst_sram_rdata_i(inst_sram_rdata_i),
        .data_sram_ren_o  (data_sram_ren_o),
        .data_sram_wen_o  (data_sram_wen_o),
        .data_sram_addr_o (data_sram_addr_o),
        .data_sram_wdata_o(data_sram_wdata_o),
        .data_sram_rdata_i(data_sram_rdata_i),
        .debug_wb_pc_o    (debug_wb_pc_o),
        .debug_wb_wen_o   (debug_wb_wen_o),
        .debug_wb_num_o   (debug_wb_num_o),
        .debug_wb_data_o  (debug_wb_data_o)
    );

    // both memories read combinationally
    assign imem_offset       = inst_sram_addr_o - `MIPS_RESET_PC;
    assign inst_sram_rdata_i = imem[imem_offset[9:2]];
    // data word only shows while the read enable is up
    assign data_sram_rdata_i = data_sram_ren_o ? dmem[data_sram_addr_o[9:2]] : '0;

    // a stalled data port commits nothing
    always @(posedge clock_i) begin
        word_t merged;
        if (!rst_i && !data_stall_i && data_sram_wen_o != 4'h0) begin
            merged = dmem[data_sram_addr_o[9:2]];
            for (int b = 0; b < 4; b++) begin
                if (data_sram_wen_o[b]) begin
                    merged[8*b +: 8] = data_sram_wdata_o[8*b +: 8];
                end
            end
            dmem[data_sram_addr_o[9:2]] <= merged;
        end
    end

    function automatic word_t encode_rtype(input logic [5:0] funct, input reg_addr_t rd,
                                           input reg_addr_t rs, input reg_addr_t rt);
        return {`MIPS_OP_SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic word_t encode_itype(input logic [5:0] op, input reg_addr_t rt,
                                           input reg_addr_t rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic check_word(input string name, input string what, input word_t exp,
                              input word_t act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("FAIL %s %s: expected %h, actual %h", name, what, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("FAIL %s num: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_en(input string name, input string what, input byte_en_t exp,
                            input byte_en_t act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("FAIL %s %s: expected %b, actual %b", name, what, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input string what, input logic exp,
                             input logic act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("FAIL %s %s: expected %b, actual %b", name, what, exp, act);
        end
    endtask

    // unused code space holds an undefined opcode, which retires as a no-op
    task automatic load_memories();
        word_t idx;
        for (int i = 0; i < 256; i++) begin
            idx = word_t'(i);
            imem[i] = (i < prog.size()) ? prog[i] : {6'h3f, idx[25:0]};
            dmem[i] = {idx[15:0] ^ 16'hc3a5, ~idx[15:0]} ^ (idx * 32'h01000193);
            ref_mem[i] = dmem[i];
        end
    endtask

    // in-order model of the kept instruction set
    task automatic interpret_program();
        word_t     regs [0:31];
        word_t     inst;
        word_t     pc;
        word_t     rs_v;
        word_t     rt_v;
        word_t     addr;
        word_t     value;
        reg_addr_t dest;
        logic      writes;
        store_t    st;
        wb_t       wr;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        exp_writes.delete();
        exp_stores.delete();
        for (int i = 0; i < prog.size(); i++) begin
            inst   = prog[i];
            pc     = `MIPS_RESET_PC + word_t'(i * 4);
            rs_v   = regs[inst[25:21]];
            rt_v   = regs[inst[20:16]];
            addr   = rs_v + {{16{inst[15]}}, inst[15:0]};
            dest   = inst[20:16];
            writes = 1'b1;
            value  = '0;
            case (inst[31:26])
                `MIPS_OP_SPECIAL: begin
                    dest = inst[15:11];
                    case (inst[5:0])
                        `MIPS_FUNCT_ADDU: value = rs_v + rt_v;
                        `MIPS_FUNCT_SUBU: value = rs_v - rt_v;
                        `MIPS_FUNCT_AND:  value = rs_v & rt_v;
                        `MIPS_FUNCT_OR:   value = rs_v | rt_v;
                        `MIPS_FUNCT_XOR:  value = rs_v ^ rt_v;
                        `MIPS_FUNCT_SLT:  value = ($signed(rs_v) < $signed(rt_v)) ? 32'd1 : 32'd0;
                        default:          writes = 1'b0;
                    endcase
                end
                `MIPS_OP_ADDIU: value = addr;
                `MIPS_OP_ORI:   value = rs_v | {16'h0000, inst[15:0]};
                `MIPS_OP_LUI:   value = {inst[15:0], 16'h0000};
                `MIPS_OP_LW:    value = ref_mem[addr[9:2]];
                `MIPS_OP_SW: begin
                    writes = 1'b0;
                    ref_mem[addr[9:2]] = rt_v;
                    st = '{addr: addr, en: 4'hF, data: rt_v};
                    exp_stores.push_back(st);
                end
                `MIPS_OP_SB: begin
                    writes = 1'b0;
                    ref_mem[addr[9:2]][8*addr[1:0] +: 8] = rt_v[7:0];
                    st = '{addr: addr, en: 4'h0, data: {4{rt_v[7:0]}}};
                    st.en[addr[1:0]] = 1'b1;
                    exp_stores.push_back(st);
                end
                default: writes = 1'b0;
            endcase
            if (writes) begin
                wr = '{pc: pc, we: 1'b1, dest: dest, data: value};
                exp_writes.push_back(wr);
                if (dest != '0) begin
                    regs[dest] = value;
                end
            end
        end
    endtask

    task automatic start_program();
        @(negedge clock_i);
        rst_i        = 1'b1;
        data_stall_i = 1'b0;
        load_memories();
        interpret_program();
        repeat (4) @(negedge clock_i);
        rst_i = 1'b0;
    endtask

    // retirements and committed stores are popped against the model
    task automatic run_and_check(input string name, input logic with_stalls);
        int     cycles;
        logic   stall_next;
        wb_t    exp_wb;
        store_t exp_st;
        cycles = 0;
        while (exp_writes.size() > 0 || exp_stores.size() > 0) begin
            @(negedge clock_i);
            cycles++;
            if (debug_wb_wen_o != 4'h0) begin
                if (exp_writes.size() == 0) begin
                    other_errors++;
                    $display("%s: unexpected register write retired at pc %h", name,
                             debug_wb_pc_o);
                end else begin
                    exp_wb = exp_writes.pop_front();
                    check_en(name, "wen", 4'hF, debug_wb_wen_o);
                    check_word(name, "pc", exp_wb.pc, debug_wb_pc_o);
                    check_reg(name, exp_wb.dest, debug_wb_num_o);
                    check_word(name, "data", exp_wb.data, debug_wb_data_o);
                end
            end
            stall_next   = with_stalls && ($urandom_range(0, 2) == 0);
            data_stall_i = stall_next;
            if (data_sram_wen_o != 4'h0 && !stall_next) begin
                if (exp_stores.size() == 0) begin
                    other_errors++;
                    $display("%s: unexpected store to %h", name, data_sram_addr_o);
                end else begin
                    exp_st = exp_stores.pop_front();
                    check_word(name, "addr", exp_st.addr, data_sram_addr_o);
                    check_en(name, "byte enables", exp_st.en, data_sram_wen_o);
                    check_word(name, "wdata", exp_st.data, data_sram_wdata_o);
                end
            end
            if (cycles >= 400) begin
                other_errors++;
                $display("%s: timed out with %0d writes and %0d stores still missing", name,
                         exp_writes.size(), exp_stores.size());
                break;
            end
        end
        @(negedge clock_i);
        data_stall_i = 1'b0;
        // only no-ops remain in flight
        repeat (8) begin
            @(negedge clock_i);
            if (debug_wb_wen_o != 4'h0 || data_sram_wen_o != 4'h0) begin
                other_errors++;
                $display("%s: extra write after the program ended", name);
            end
        end
    endtask

    task automatic test_reset();
        word_t prev;
        prog.delete();
        @(negedge clock_i);
        rst_i        = 1'b1;
        data_stall_i = 1'b0;
        load_memories();
        repeat (4) begin
            @(negedge clock_i);
            check_en("test_reset", "debug wen", 4'h0, debug_wb_wen_o);
            check_en("test_reset", "data wen", 4'h0, data_sram_wen_o);
            check_bit("test_reset", "data ren", 1'b0, data_sram_ren_o);
            check_bit("test_reset", "inst ren", 1'b0, inst_sram_ren_o);
            check_word("test_reset", "fetch addr", `MIPS_RESET_PC, inst_sram_addr_o);
        end
        rst_i = 1'b0;
        @(negedge clock_i);
        check_en("test_reset", "debug wen", 4'h0, debug_wb_wen_o);
        check_en("test_reset", "data wen", 4'h0, data_sram_wen_o);
        check_bit("test_reset", "inst ren", 1'b1, inst_sram_ren_o);
        check_word("test_reset", "fetch addr", `MIPS_RESET_PC, inst_sram_addr_o);
        prev = inst_sram_addr_o;
        repeat (6) begin
            @(negedge clock_i);
            check_word("test_reset", "fetch addr", prev + 32'd4, inst_sram_addr_o);
            prev = inst_sram_addr_o;
        end
    endtask

    task automatic test_alu();
        prog.delete();
        prog.push_back(encode_itype(`MIPS_OP_ADDIU, 5'd1, 5'd0, 16'h1234));
        prog.push_back(encode_itype(`MIPS_OP_ADDIU, 5'd2, 5'd0, 16'hfffb));
        prog.push_back(encode_itype(`MIPS_OP_ORI, 5'd3, 5'd0, 16'h8001));
        prog.push_back(encode_itype(`MIPS_OP_LUI, 5'd4, 5'd0, 16'ha5c3));
        prog.push_back(encode_itype(`MIPS_OP_ADDIU, 5'd5, 5'd0, 16'h0077));
        prog.push_back(encode_rtype(`MIPS_FUNCT_ADDU, 5'd6, 5'd1, 5'd2));
        prog.push_back(encode_rtype(`MIPS_FUNCT_SUBU, 5'd7, 5'd3, 5'd1));
        prog.push_back(encode_rtype(`MIPS_FUNCT_AND, 5'd8, 5'd4, 5'd2));
        prog.push_back(encode_rtype(`MIPS_FUNCT_OR, 5'd9, 5'd3, 5'd4));
        prog.push_back(encode_rtype(`MIPS_FUNCT_XOR, 5'd10, 5'd1, 5'd3));
        // negative against positive, both ways
        prog.push_back(encode_rtype(`MIPS_FUNCT_SLT, 5'd11, 5'd2, 5'd1));
        prog.push_back(encode_rtype(`MIPS_FUNCT_SLT, 5'd12, 5'd1, 5'd2));
        prog.push_back(encode_rtype(`MIPS_FUNCT_SLT, 5'd13, 5'd4, 5'd5));
        start_program();
        run_and_check("test_alu", 1'b0);
    endtask

    task automatic test_forwarding();
        prog.delete();
        prog.push_back(encode_itype(`MIPS_OP_ADDIU, 5'd1, 5'd0, 16'h0005));
        prog.push_back(encode_itype(`MIPS_OP_ADDIU, 5'd2, 5'd1, 16'h0003));
        prog.push_back(encode_rtype(`MIPS_FUNCT_ADDU, 5'd3, 5'd2, 5'd1));
        prog.push_back(encode_rtype(`MIPS_FUNCT_SUBU, 5'd4, 5'd3, 5'd2));
        prog.push_back(encode_rtype(`MIPS_FUNCT_OR, 5'd5, 5'd1, 5'd4));
        // r3 at distance 3 goes through the register file
        prog.push_back(encode_rtype(`MIPS_FUNCT_XOR, 5'd6, 5'd3, 5'd5));
        prog.push_back(encode_rtype(`MIPS_FUNCT_ADDU, 5'd7, 5'd6, 5'd6));
        prog.push_back(encode_itype(`MIPS_OP_ADDIU, 5'd1, 5'd7, 16'hffff));
        prog.push_back(encode_rtype(`MIPS_FUNCT_ADDU, 5'd8, 5'd1, 5'd1));
        prog.push_back(encode_itype(`MIPS_OP_ORI, 5'd9, 5'd8, 16'hf000));
        start_program();
        run_and_check("test_forwarding", 1'b0);
    endtask

    task automatic build_load_store_program();
        prog.delete();
        prog.push_back(encode_itype(`MIPS_OP_ADDIU, 5'd1, 5'd0, 16'h0100));
        prog.push_back(encode_itype(`MIPS_OP_LUI, 5'd2, 5'd0, 16'h1122));
        prog.push_back(encode_itype(`MIPS_OP_ORI, 5'd2, 5'd2, 16'h3344));
        prog.push_back(encode_itype(`MIPS_OP_SW, 5'd2, 5'd1, 16'h0000));
        prog.push_back(encode_itype(`MIPS_OP_ADDIU, 5'd3, 5'd0, 16'h05a1));
        prog.push_back(encode_itype(`MIPS_OP_SB, 5'd3, 5'd1, 16'h0004));
        prog.push_back(encode_itype(`MIPS_OP_ADDIU, 5'd4, 5'd0, 16'h00b2));
        prog.push_back(encode_itype(`MIPS_OP_SB, 5'd4, 5'd1, 16'h0005));
        prog.push_back(encode_itype(`MIPS_OP_ADDIU, 5'd5, 5'd0, 16'h7fc3));
        prog.push_back(encode_itype(`MIPS_OP_SB, 5'd5, 5'd1, 16'h0006));
        prog.push_back(encode_itype(`MIPS_OP_ADDIU, 5'd6, 5'd0, 16'hffd4));
        prog.push_back(encode_itype(`MIPS_OP_SB, 5'd6, 5'd1, 16'h0007));
        // load-use pairs, through rs, rt and the store data
        prog.push_back(encode_itype(`MIPS_OP_LW, 5'd7, 5'd1, 16'h0004));
        prog.push_back(encode_rtype(`MIPS_FUNCT_ADDU, 5'd8, 5'd7, 5'd2));
        prog.push_back(encode_itype(`MIPS_OP_LW, 5'd9, 5'd1, 16'h0000));
        prog.push_back(encode_rtype(`MIPS_FUNCT_SUBU, 5'd10, 5'd2, 5'd9));
        prog.push_back(encode_itype(`MIPS_OP_LW, 5'd11, 5'd1, 16'h0008));
        prog.push_back(encode_itype(`MIPS_OP_SB, 5'd11, 5'd1, 16'h0009));
        prog.push_back(encode_itype(`MIPS_OP_LW, 5'd12, 5'd1, 16'h0008));
        prog.push_back(encode_rtype(`MIPS_FUNCT_XOR, 5'd13, 5'd12, 5'd11));
    endtask

    task automatic test_load_store();
        build_load_store_program();
        start_program();
        run_and_check("test_load_store", 1'b0);
    endtask

    task automatic test_data_stall();
        build_load_store_program();
        start_program();
        run_and_check("test_data_stall", 1'b1);
    endtask

    initial begin
        rst_i        = 1'b1;
        data_stall_i = 1'b0;
        void'($urandom(32'h7d07b504));
        prog.delete();
        load_memories();
        test_reset();
        test_alu();
        test_forwarding();
        test_load_store();
        test_data_stall();
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches,
                 other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end
endmodule

// File: verilog.f
+incdir+common
common/mips_pkg.sv
verilog/mips_fetch.sv
decode/mips_regfile.sv
decode/mips_decode.sv
execute/mips_execute.sv
verilog/mips_memory.sv
verilog/mips_top.sv
tb/tb_mips_top.sv

// File: verilog/mips_fetch.sv
`timescale 1ns/10ps
`include "mips_macros.svh"
module mips_fetch (
    input  logic            clock_i,
    input  logic            rst_i,
    input  logic            load_stall_i,
    input  logic            data_stall_i,
    input  mips_pkg::word_t inst_sram_rdata_i,
    output mips_pkg::word_t inst_sram_addr_o,
    output logic            inst_sram_ren_o,
    output mips_pkg::word_t if_pc_o,
    output mips_pkg::word_t if_inst_o
);
    import mips_pkg::*;

    word_t pc_q;
    word_t if_pc_q;
    word_t if_inst_q;
    logic  ren_q;
    logic  hold;

    assign hold = load_stall_i || data_stall_i;

    assign inst_sram_addr_o = pc_q;
    assign inst_sram_ren_o  = ren_q;
    assign if_pc_o          = if_pc_q;
    assign if_inst_o        = if_inst_q;

    // pc waits one cycle after reset until the read enable is up
    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            pc_q  <= `MIPS_RESET_PC;
            ren_q <= 1'b0;
        end else begin
            ren_q <= 1'b1;
            if (ren_q && !hold) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    // zero instruction is an sll no-op
    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            if_pc_q   <= '0;
            if_inst_q <= '0;
        end else if (!hold) begin
            if_pc_q   <= pc_q;
            if_inst_q <= ren_q ? inst_sram_rdata_i : '0;
        end
    end

    a_pc_aligned: assert property (@(posedge clock_i) disable iff (rst_i)
        pc_q[1:0] == 2'b00);
endmodule

// File: verilog/mips_memory.sv
`timescale 1ns/10ps
module mips_memory (
    input  logic               clock_i,
    input  logic               rst_i,
    input  logic               data_stall_i,
    input  mips_pkg::ex_mem_t  ex_mem_i,
    input  mips_pkg::word_t    data_sram_rdata_i,
    output logic               data_sram_ren_o,
    output mips_pkg::byte_en_t data_sram_wen_o,
    output mips_pkg::word_t    data_sram_addr_o,
    output mips_pkg::word_t    data_sram_wdata_o,
    output mips_pkg::wb_t      mem_fwd_o,
    output mips_pkg::wb_t      wb_o
);
    import mips_pkg::*;

    byte_en_t byte_en;
    word_t    wb_data;
    wb_t      wb_d;
    wb_t      wb_q;

    // sb picks one lane by the low address bits
    assign byte_en = ex_mem_i.ctrl.mem_byte ? (4'b0001 << ex_mem_i.result[1:0]) : 4'hF;

    assign data_sram_ren_o   = ex_mem_i.ctrl.mem_read;
    assign data_sram_wen_o   = ex_mem_i.ctrl.mem_write ? byte_en : 4'h0;
    assign data_sram_addr_o  = ex_mem_i.result;
    assign data_sram_wdata_o = ex_mem_i.ctrl.mem_byte ? {4{ex_mem_i.store_data[7:0]}}
                                                      : ex_mem_i.store_data;

    assign wb_data = ex_mem_i.ctrl.mem_read ? data_sram_rdata_i : ex_mem_i.result;
    assign wb_d    = '{pc: ex_mem_i.pc, we: ex_mem_i.ctrl.reg_write,
                       dest: ex_mem_i.ctrl.dest, data: wb_data};

    // forward the real value even while writeback takes a bubble
    assign mem_fwd_o = wb_d;

    always_ff @(posedge clock_i) begin
        if (rst_i || data_stall_i) begin
            wb_q <= '0;
        end else begin
            wb_q <= wb_d;
        end
    end

    assign wb_o = wb_q;

    a_no_stray_write: assert property (@(posedge clock_i) disable iff (rst_i)
        !ex_mem_i.ctrl.mem_write |-> data_sram_wen_o == '0);

    // execute holds its register, so the data port must not move
    a_stall_stable: assert property (@(posedge clock_i) disable iff (rst_i)
        data_stall_i |=> $stable(data_sram_addr_o) && $stable(data_sram_wen_o));
endmodule

// File: verilog/mips_top.sv
`timescale 1ns/10ps
module mips_top (
    input  logic                clock_i,
    input  logic                rst_i,
    input  logic                data_stall_i,

    output mips_pkg::word_t     inst_sram_addr_o,
    output logic                inst_sram_ren_o,
    input  mips_pkg::word_t     inst_sram_rdata_i,

    output logic                data_sram_ren_o,
    output mips_pkg::byte_en_t  data_sram_wen_o,
    output mips_pkg::word_t     data_sram_addr_o,
    output mips_pkg::word_t     data_sram_wdata_o,
    input  mips_pkg::word_t     data_sram_rdata_i,

    output mips_pkg::word_t     debug_wb_pc_o,
    output mips_pkg::byte_en_t  debug_wb_wen_o,
    output mips_pkg::reg_addr_t debug_wb_num_o,
    output mips_pkg::word_t     debug_wb_data_o
);
    import mips_pkg::*;

    word_t     if_pc;
    word_t     if_inst;
    logic      load_stall;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;
    wb_t       ex_fwd;
    wb_t       mem_fwd;
    logic      ex_is_load;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    wb_t       wb;

    // debug port mirrors the retiring write
    assign debug_wb_pc_o   = wb.pc;
    assign debug_wb_wen_o  = {4{wb.we}};
    assign debug_wb_num_o  = wb.dest;
    assign debug_wb_data_o = wb.data;

    mips_fetch if_stage (
        .clock_i          (clock_i),
        .rst_i            (rst_i),
        .load_stall_i     (load_stall),
        .data_stall_i     (data_stall_i),
        .inst_sram_rdata_i(inst_sram_rdata_i),
        .inst_sram_addr_o (inst_sram_addr_o),
        .inst_sram_ren_o  (inst_sram_ren_o),
        .if_pc_o          (if_pc),
        .if_inst_o        (if_inst)
    );

    mips_decode id_stage (
        .clock_i     (clock_i),
        .rst_i       (rst_i),
        .data_stall_i(data_stall_i),
        .if_pc_i     (if_pc),
        .if_inst_i   (if_inst),
        .rs_data_i   (rs_data),
        .rt_data_i   (rt_data),
        .rs_addr_o   (rs_addr),
        .rt_addr_o   (rt_addr),
        .ex_fwd_i    (ex_fwd),
        .mem_fwd_i   (mem_fwd),
        .ex_is_load_i(ex_is_load),
        .load_stall_o(load_stall),
        .id_ex_o     (id_ex)
    );

    mips_regfile regfile (
        .clock_i  (clock_i),
        .rst_i    (rst_i),
        .rs_addr_i(rs_addr),
        .rt_addr_i(rt_addr),
        .wb_i     (wb),
        .rs_data_o(rs_data),
        .rt_data_o(rt_data)
    );

    mips_execute ex_stage (
        .clock_i     (clock_i),
        .rst_i       (rst_i),
        .data_stall_i(data_stall_i),
        .id_ex_i     (id_ex),
        .ex_mem_o    (ex_mem),
        .ex_fwd_o    (ex_fwd),
        .ex_is_load_o(ex_is_load)
    );

    mips_memory mem_stage (
        .clock_i          (clock_i),
        .rst_i            (rst_i),
        .data_stall_i     (data_stall_i),
        .ex_mem_i         (ex_mem),
        .data_sram_rdata_i(data_sram_rdata_i),
        .data_sram_ren_o  (data_sram_ren_o),
        .data_sram_wen_o  (data_sram_wen_o),
        .data_sram_addr_o (data_sram_addr_o),
        .data_sram_wdata_o(data_sram_wdata_o),
        .mem_fwd_o        (mem_fwd),
        .wb_o             (wb)
    );
endmodule
